/* Makefile */
# Verilator build and run of the two-lane link testbench
# the run passes only when the log holds the pass line

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module lane_link_tb -Mdir obj_dir
	-./obj_dir/Vlane_link_tb > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* sim.f */
source/lane_pkg.sv
source/lane_if.sv
source/lane_distributer.sv
source/lane_fifo.sv
source/lane_merger.sv
source/lane_link_top.sv
tb/lane_link_props.sv
tb/lane_link_tb.sv

/* source/lane_distributer.sv */
////////////////////////////////////////////////////////////////////////////
// transmit striping for the two-lane link
// takes one byte per data_valid strobe while enable_t is high and writes
// it to lane 0 or lane 1 in alternating blocks of BLOCK_LEN bytes
// the lane strobe is registered, so the fifo write lands one edge later
////////////////////////////////////////////////////////////////////////////

module lane_distributer
  import lane_pkg::*;
#(
  parameter int BLOCK_LEN = 8                   // bytes per lane block
)
(
  input  logic      clk_a,
  input  logic      rst,                        // async, active low
  input  logic      enable_t,                   // level, low clears the side
  input  byte_t     data_in,                    // from the data bus
  input  logic      data_valid,                 // one byte per strobe
  lane_wr_if.tx     wr,                         // to the lane fifos
  output logic      tx_active                   // high one cycle after enable_t
);

  localparam int CNT_W = (BLOCK_LEN > 1) ? $clog2(BLOCK_LEN) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLOCK_LEN - 1);

  logic [CNT_W-1:0] blk_cnt;                    // bytes sent in this block
  lane_sel_e        lane;                       // lane taking the next byte
  logic             accept;                     // byte taken this cycle

  assign accept = data_valid & enable_t;

  //////////////////////////////////////////////////////////////////////////
  // block counter, lane select and write strobes
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_a or negedge rst)
  begin
    if (!rst)
    begin
      blk_cnt     <= '0;
      lane        <= LANE_0;
      tx_active   <= 1'b0;
      wr.lane0_wr <= 1'b0;
      wr.lane1_wr <= 1'b0;
    end
    else if (!enable_t)
    begin
      blk_cnt     <= '0;                        // restart on lane 0
      lane        <= LANE_0;
      tx_active   <= 1'b0;
      wr.lane0_wr <= 1'b0;
      wr.lane1_wr <= 1'b0;
    end
    else
    begin
      tx_active   <= 1'b1;
      wr.lane0_wr <= accept & (lane == LANE_0); // strobe to selected lane only
      wr.lane1_wr <= accept & (lane == LANE_1);
      if (accept)
      begin
        if (blk_cnt == CNT_LAST)
        begin
          blk_cnt <= '0;                        // block done
          lane    <= next_lane(lane);           // swap lanes
        end
        else
        begin
          blk_cnt <= blk_cnt + 1'b1;
        end
      end
    end
  end

  // payload beside the strobes, no reset needed
  always_ff @(posedge clk_a)
  begin
    if (accept && lane == LANE_0)
      wr.lane0_data <= data_in;
    if (accept && lane == LANE_1)
      wr.lane1_data <= data_in;
  end

endmodule

/* source/lane_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// byte FIFO for one lane of the link
// circular buffer of FIFO_DEPTH entries, depth a power of two; the head is
// shown combinationally on rd_data and rd_en pops it at the clock edge
// a write while full is dropped and sets the sticky overflow flag
////////////////////////////////////////////////////////////////////////////

module lane_fifo
  import lane_pkg::*;
#(
  parameter int FIFO_DEPTH = 16                 // entries, power of two
)
(
  input  logic  clk_a,
  input  logic  rst,                            // async, active low
  input  logic  wr_en,                          // write strobe from distributer
  input  byte_t wr_data,
  input  logic  rd_en,                          // pop strobe from merger
  output byte_t rd_data,                        // current head
  output logic  empty,
  output logic  overflow                        // sticky until reset
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  byte_t       mem [FIFO_DEPTH];                // storage, no reset
  logic [AW:0] wr_ptr;                          // extra msb for wrap
  logic [AW:0] rd_ptr;
  logic        full;
  logic        do_wr;
  logic        do_rd;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]); // same slot, one lap ahead
  assign do_wr = wr_en & ~full;                 // full write is lost
  assign do_rd = rd_en & ~empty;                // guard, merger never pops empty

  assign rd_data = mem[rd_ptr[AW-1:0]];

  // pointers and overflow flag
  always_ff @(posedge clk_a or negedge rst)
  begin
    if (!rst)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      if (wr_en && full)
        overflow <= 1'b1;                       // latch, cleared by reset only
    end
  end

  // data array write
  always_ff @(posedge clk_a)
  begin
    if (do_wr)
      mem[wr_ptr[AW-1:0]] <= wr_data;
  end

endmodule

/* source/lane_if.sv */
////////////////////////////////////////////////////////////////////////////
// lane buses between the striping blocks and the lane FIFOs
// lane_wr_if carries the write strobes and bytes from the distributer,
// lane_rd_if carries the pop strobes from the merger and the FIFO heads
////////////////////////////////////////////////////////////////////////////

interface lane_wr_if import lane_pkg::*; ();
  logic  lane0_wr;                              // one-cycle write pulse
  logic  lane1_wr;
  byte_t lane0_data;                            // valid with its strobe
  byte_t lane1_data;

  modport tx (output lane0_wr, lane1_wr, lane0_data, lane1_data);
  modport rx (input  lane0_wr, lane1_wr, lane0_data, lane1_data);
endinterface

interface lane_rd_if import lane_pkg::*; ();
  logic  lane0_rd;                              // pops head at the edge
  logic  lane1_rd;
  logic  lane0_empty;
  logic  lane1_empty;
  byte_t lane0_data;                            // fifo head, combinational
  byte_t lane1_data;

  modport sink   (output lane0_rd, lane1_rd,
                  input  lane0_empty, lane1_empty, lane0_data, lane1_data);
  modport source (input  lane0_rd, lane1_rd,
                  output lane0_empty, lane1_empty, lane0_data, lane1_data);
endinterface

/* source/lane_link_top.sv */
////////////////////////////////////////////////////////////////////////////
// top level of the two-lane byte striping link
// distributer -> two lane fifos -> merger, all on clk_a
// BLOCK_LEN and FIFO_DEPTH are set here and handed to the blocks below;
// overflow reports a dropped write on either lane
////////////////////////////////////////////////////////////////////////////

module lane_link_top
  import lane_pkg::*;
#(
  parameter int BLOCK_LEN  = 8,                 // bytes per lane block
  parameter int FIFO_DEPTH = 16                 // lane fifo entries
)
(
  input  logic  clk_a,
  input  logic  rst,                            // async, active low
  input  logic  enable_t,                       // transmit side enable
  input  logic  enable_r,                       // receive side enable
  input  byte_t data_in,
  input  logic  data_valid,
  output byte_t data_out,
  output logic  data_out_valid,
  output logic  tx_active,
  output logic  rx_lanes_on,
  output logic  overflow                        // sticky, either lane
);

  logic lane0_ovf;
  logic lane1_ovf;

  lane_wr_if wr_bus ();                         // distributer to fifos
  lane_rd_if rd_bus ();                         // fifos to merger

  lane_distributer #(.BLOCK_LEN(BLOCK_LEN)) lane_distributer_inst (
    .clk_a      (clk_a),
    .rst        (rst),
    .enable_t   (enable_t),
    .data_in    (data_in),
    .data_valid (data_valid),
    .wr         (wr_bus.tx),
    .tx_active  (tx_active)
  );

  //////////////////////////////////////////////////////////////////////////
  // lane fifos
  //////////////////////////////////////////////////////////////////////////
  lane_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) lane0_fifo (
    .clk_a    (clk_a),
    .rst      (rst),
    .wr_en    (wr_bus.lane0_wr),
    .wr_data  (wr_bus.lane0_data),
    .rd_en    (rd_bus.lane0_rd),
    .rd_data  (rd_bus.lane0_data),
    .empty    (rd_bus.lane0_empty),
    .overflow (lane0_ovf)
  );

  lane_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) lane1_fifo (
    .clk_a    (clk_a),
    .rst      (rst),
    .wr_en    (wr_bus.lane1_wr),
    .wr_data  (wr_bus.lane1_data),
    .rd_en    (rd_bus.lane1_rd),
    .rd_data  (rd_bus.lane1_data),
    .empty    (rd_bus.lane1_empty),
    .overflow (lane1_ovf)
  );

  lane_merger #(.BLOCK_LEN(BLOCK_LEN)) lane_merger_inst (
    .clk_a          (clk_a),
    .rst            (rst),
    .enable_r       (enable_r),
    .rd             (rd_bus.sink),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .rx_lanes_on    (rx_lanes_on)
  );

  assign overflow = lane0_ovf | lane1_ovf;      // either lane dropped a byte

endmodule

/* source/lane_merger.sv */
////////////////////////////////////////////////////////////////////////////
// receive merging for the two-lane link
// pops BLOCK_LEN bytes from lane 0, then BLOCK_LEN from lane 1 and so on,
// which restores the byte order on data_out with a data_out_valid pulse
// the pop strobe is combinational, so a byte leaves one edge after it lands
// enable_r low parks the FSM and puts the lane select back on lane 0
////////////////////////////////////////////////////////////////////////////

module lane_merger
  import lane_pkg::*;
#(
  parameter int BLOCK_LEN = 8                   // bytes per lane block
)
(
  input  logic      clk_a,
  input  logic      rst,                        // async, active low
  input  logic      enable_r,                   // level, low clears the side
  lane_rd_if.sink   rd,                         // from the lane fifos
  output byte_t     data_out,                   // to the data bus
  output logic      data_out_valid,             // one pulse per byte
  output logic      rx_lanes_on                 // high one cycle after enable_r
);

  localparam int CNT_W = (BLOCK_LEN > 1) ? $clog2(BLOCK_LEN) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLOCK_LEN - 1);

  merge_state_e     state;
  lane_sel_e        lane;                       // lane being drained
  logic [CNT_W-1:0] pop_cnt;                    // bytes popped in this block
  logic             cur_empty;                  // current lane has nothing
  byte_t            cur_data;                   // head of the current lane
  logic             pop;

  //////////////////////////////////////////////////////////////////////////
  // lane mux and pop strobes
  //////////////////////////////////////////////////////////////////////////
  assign cur_empty = (lane == LANE_1) ? rd.lane1_empty : rd.lane0_empty;
  assign cur_data  = (lane == LANE_1) ? rd.lane1_data  : rd.lane0_data;
  assign pop       = enable_r & ~cur_empty;     // never pops an empty lane

  assign rd.lane0_rd = pop & (lane == LANE_0);
  assign rd.lane1_rd = pop & (lane == LANE_1);

  assign rx_lanes_on = (state != M_OFF);        // registered via the FSM

  //////////////////////////////////////////////////////////////////////////
  // FSM, block counter and lane select
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_a or negedge rst)
  begin
    if (!rst)
    begin
      state          <= M_OFF;
      lane           <= LANE_0;
      pop_cnt        <= '0;
      data_out_valid <= 1'b0;
    end
    else if (!enable_r)
    begin
      state          <= M_OFF;                  // bytes pile up in the fifos
      lane           <= LANE_0;
      pop_cnt        <= '0;
      data_out_valid <= 1'b0;
    end
    else
    begin
      state          <= pop ? M_READ : M_WAIT;
      data_out_valid <= pop;
      if (pop)
      begin
        if (pop_cnt == CNT_LAST)
        begin
          pop_cnt <= '0;                        // block drained
          lane    <= next_lane(lane);
        end
        else
        begin
          pop_cnt <= pop_cnt + 1'b1;
        end
      end
    end
  end

  // output byte, payload only
  always_ff @(posedge clk_a)
  begin
    if (pop)
      data_out <= cur_data;
  end

endmodule

/* source/lane_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared types for the two-lane byte striping link
// holds the lane count, the byte type, the lane select and merger state
// enums, and the lane stepping helper used by both sides of the link
// import with a wildcard in the header of any module that needs them
////////////////////////////////////////////////////////////////////////////

package lane_pkg;

  localparam int NUM_LANES = 2;                 // lanes in the link

  typedef logic [7:0] byte_t;                   // one payload byte

  // current lane of the distributer and the merger
  typedef enum logic [$clog2(NUM_LANES)-1:0] {
    LANE_0 = 1'b0,                              // first block goes here
    LANE_1 = 1'b1
  } lane_sel_e;

  // merger FSM states
  typedef enum logic [1:0] {
    M_OFF  = 2'd0,                              // enable_r low, lanes idle
    M_WAIT = 2'd1,                              // current lane has no data
    M_READ = 2'd2                               // byte popped last cycle
  } merge_state_e;

  // step to the next lane at a block end, wraps after the last lane
  function automatic lane_sel_e next_lane(input lane_sel_e cur);
    int nxt;
    nxt = (int'(cur) + 1) % NUM_LANES;          // round robin over lanes
    return lane_sel_e'(nxt);
  endfunction

endpackage

/* tb/lane_link_props.sv */
////////////////////////////////////////////////////////////////////////////
// protocol checks for the two-lane link, bound to lane_link_top
// watches the merger output, the lane pop strobes and the overflow flag
////////////////////////////////////////////////////////////////////////////

module lane_link_props (
  input logic clk_a,
  input logic rst,
  input logic data_out_valid,
  input logic rx_lanes_on,
  input logic overflow,
  input logic lane0_rd,                         // merger pop strobes
  input logic lane1_rd,
  input logic lane0_empty,                      // fifo empty flags
  input logic lane1_empty
);

  // output pulse only while the receive side is on
  valid_needs_rx_on: assert property (@(posedge clk_a) disable iff (!rst)
    data_out_valid |-> rx_lanes_on)
    else $error("data_out_valid high while rx_lanes_on is low");

  // no pop from an empty lane
  lane0_pop_not_empty: assert property (@(posedge clk_a) disable iff (!rst)
    lane0_rd |-> !lane0_empty)
    else $error("lane 0 read strobe while lane 0 is empty");

  lane1_pop_not_empty: assert property (@(posedge clk_a) disable iff (!rst)
    lane1_rd |-> !lane1_empty)
    else $error("lane 1 read strobe while lane 1 is empty");

  // sticky until reset
  overflow_sticky: assert property (@(posedge clk_a) disable iff (!rst)
    !$fell(overflow))
    else $error("overflow fell without a reset");

endmodule

bind lane_link_top lane_link_props lane_link_props_inst (
  .clk_a          (clk_a),
  .rst            (rst),
  .data_out_valid (data_out_valid),
  .rx_lanes_on    (rx_lanes_on),
  .overflow       (overflow),
  .lane0_rd       (rd_bus.lane0_rd),
  .lane1_rd       (rd_bus.lane1_rd),
  .lane0_empty    (rd_bus.lane0_empty),
  .lane1_empty    (rd_bus.lane1_empty)
);

/* tb/lane_link_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the two-lane byte striping link
// walks a table of rows through lane_link_top; each row sends a byte
// stream, may hold the receive side off or restart both sides, and a
// scoreboard queue checks every data_out byte and the lane it crossed
// lane_link_props is bound to the DUT for the protocol rules
////////////////////////////////////////////////////////////////////////////

module lane_link_tb import lane_pkg::*; ();

  localparam int BLOCK_LEN  = 8;
  localparam int FIFO_DEPTH = 16;
  localparam int NUM_ROWS   = 5;
  localparam int DRAIN_MAX  = 300;              // cycles to empty the queue

  typedef struct {
    string name;
    int    count;                               // bytes sent in the row
    int    holdoff;                             // cycles enable_r stays low after sending
    bit    rand_data;                           // 0 incrementing, 1 $random
    int    gap_pct;                             // chance of an idle gap per byte
    int    toggle_at;                           // restart both sides before this byte
    logic  exp_ovf;
  } test_row_t;

  logic  clk_a;
  logic  rst;
  logic  enable_t;
  logic  enable_r;
  byte_t data_in;
  logic  data_valid;
  byte_t data_out;
  logic  data_out_valid;
  logic  tx_active;
  logic  rx_lanes_on;
  logic  overflow;

  test_row_t rows [NUM_ROWS];
  byte_t     exp_q [$];                         // bytes still to come out
  lane_sel_e lane_q [$];                        // lane each byte was striped to
  lane_sel_e popped_lane = LANE_0;              // lane the merger drained last cycle
  integer    seed = 32'hfb94da8e;
  string     cur_name = "reset";
  int        cycle = 0;                         // rising edges so far
  int        tx_idx = 0;                        // bytes since tx restart
  int        rx_in_row = 0;
  int        first_acc_cyc = 0;
  int        first_out_cyc = 0;
  int        row_idx;
  int        lane_cnt [NUM_LANES];              // fifo fill while rx held off

  initial clk_a = 1'b0;
  always #2 clk_a = ~clk_a;                     // period 4
  always @(posedge clk_a) cycle <= cycle + 1;

  lane_link_top #(
    .BLOCK_LEN  (BLOCK_LEN),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) lane_link_top_inst (
    .clk_a          (clk_a),
    .rst            (rst),
    .enable_t       (enable_t),
    .enable_r       (enable_r),
    .data_in        (data_in),
    .data_valid     (data_valid),
    .data_out       (data_out),
    .data_out_valid (data_out_valid),
    .tx_active      (tx_active),
    .rx_lanes_on    (rx_lanes_on),
    .overflow       (overflow)
  );

  //////////////////////////////////////////////////////////////////////////
  // compare tasks that end the run at the first mismatch
  //////////////////////////////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    if (exp !== act)
      abort_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act)
      abort_run($sformatf("ERR %s expected %b actual %b", name, exp, act));
  endtask

  task automatic check_lane(input string name, input lane_sel_e exp, input lane_sel_e act);
    if (exp !== act)
      abort_run($sformatf("ERR %s expected %s actual %s", name, exp.name(), act.name()));
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (exp != act)
      abort_run($sformatf("ERR %s expected %0d actual %0d", name, exp, act));
  endtask

  // scoreboard checks each output byte at the falling edge
  always @(negedge clk_a)
  begin
    if (data_out_valid)
    begin
      if (exp_q.size() == 0)
        abort_run($sformatf("%s: data_out_valid pulsed with no byte expected", cur_name));
      else
      begin
        check_byte({cur_name, " data"}, exp_q.pop_front(), data_out);
        check_lane({cur_name, " lane"}, lane_q.pop_front(), popped_lane);
        if (rx_in_row == 0)
          first_out_cyc = cycle;
        rx_in_row++;
      end
    end
    popped_lane = lane_link_top_inst.lane_merger_inst.lane; // lane popped this cycle
  end

  //////////////////////////////////////////////////////////////////////////
  // sequencing helpers
  //////////////////////////////////////////////////////////////////////////
  task automatic apply_reset();
    @(negedge clk_a);
    rst        = 1'b0;
    enable_t   = 1'b0;
    enable_r   = 1'b0;
    data_valid = 1'b0;
    repeat (4) @(negedge clk_a);                // 4 cycles in reset
    rst    = 1'b1;
    exp_q.delete();
    lane_q.delete();
    tx_idx = 0;                                 // both sides back on lane 0
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_MAX)
    begin
      @(negedge clk_a);
      n++;
    end
    if (exp_q.size() != 0)
      abort_run($sformatf("%s: timeout, %0d bytes never came out", cur_name, exp_q.size()));
    repeat (4) @(negedge clk_a);                // room for a stray extra byte
  endtask

  task automatic restart_sides();
    data_valid = 1'b0;
    wait_drain();                               // block boundary reached and all bytes out
    enable_t   = 1'b0;
    enable_r   = 1'b0;
    repeat (3) @(negedge clk_a);
    check_flag({cur_name, " tx_active off"}, 1'b0, tx_active);
    check_flag({cur_name, " rx_lanes_on off"}, 1'b0, rx_lanes_on);
    tx_idx   = 0;                               // expect a fresh start on lane 0
    enable_t = 1'b1;
    enable_r = 1'b1;
    @(negedge clk_a);
    check_flag({cur_name, " tx_active on"}, 1'b1, tx_active);
    check_flag({cur_name, " rx_lanes_on on"}, 1'b1, rx_lanes_on);
  endtask

  task automatic run_row(input int r);
    test_row_t row;
    byte_t     b;
    lane_sel_e lane;
    int        i;
    row       = rows[r];
    cur_name  = row.name;
    rx_in_row = 0;
    lane_cnt  = '{default: 0};
    if (row.holdoff > 0)
      enable_r = 1'b0;                          // bytes pile up in the fifos
    for (i = 0; i < row.count; i++)
    begin
      if (row.toggle_at > 0 && i == row.toggle_at)
        restart_sides();
      if (row.gap_pct > 0 && $unsigned($random(seed)) % 100 < row.gap_pct)
      begin
        data_valid = 1'b0;                      // idle gap of 1 to 3 cycles
        repeat (1 + $unsigned($random(seed)) % 3) @(negedge clk_a);
      end
      b    = row.rand_data ? byte_t'($random(seed)) : byte_t'(i + 16 * r);
      lane = lane_sel_e'((tx_idx / BLOCK_LEN) % NUM_LANES); // block striping rule
      data_in    = b;
      data_valid = 1'b1;
      if (i == 0)
        first_acc_cyc = cycle + 1;              // taken at the coming edge
      if (!(row.holdoff > 0 && lane_cnt[lane] >= FIFO_DEPTH))
      begin
        exp_q.push_back(b);                     // full lane drops the byte
        lane_q.push_back(lane);
      end
      lane_cnt[lane]++;
      tx_idx++;
      @(negedge clk_a);
    end
    data_valid = 1'b0;
    if (row.holdoff > 0)
    begin
      repeat (row.holdoff) @(negedge clk_a);
      check_flag({cur_name, " rx_lanes_on held"}, 1'b0, rx_lanes_on);
      enable_r = 1'b1;
    end
    wait_drain();
    check_flag({cur_name, " overflow"}, row.exp_ovf, overflow);
    if (r == 0)
      check_count({cur_name, " latency"}, 2, first_out_cyc - first_acc_cyc);
    if (row.exp_ovf)
    begin
      apply_reset();                            // only reset clears overflow
      check_flag({cur_name, " overflow after reset"}, 1'b0, overflow);
      enable_t = 1'b1;
      enable_r = 1'b1;
      @(negedge clk_a);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////////
  initial
  begin
    rst        = 1'b0;
    enable_t   = 1'b0;
    enable_r   = 1'b0;
    data_in    = '0;
    data_valid = 1'b0;
    // name, count, holdoff, random, gap %, restart at, overflow
    rows[0] = '{"incr_back_to_back", 32, 0, 1'b0, 0, 0, 1'b0};
    rows[1] = '{"random_gaps", 48, 0, 1'b1, 40, 0, 1'b0};
    rows[2] = '{"lane0_overflow", 40, 5, 1'b0, 0, 0, 1'b1};
    rows[3] = '{"rx_held_off", 24, 5, 1'b0, 0, 0, 1'b0};
    rows[4] = '{"block_restart", 32, 0, 1'b0, 0, 16, 1'b0};
    apply_reset();
    @(negedge clk_a);
    check_flag("reset tx_active", 1'b0, tx_active);
    check_flag("reset rx_lanes_on", 1'b0, rx_lanes_on);
    check_flag("reset data_out_valid", 1'b0, data_out_valid);
    check_flag("reset overflow", 1'b0, overflow);
    enable_t = 1'b1;
    check_flag("tx_active before edge", 1'b0, tx_active);
    @(negedge clk_a);
    check_flag("tx_active after edge", 1'b1, tx_active);
    enable_r = 1'b1;
    check_flag("rx_lanes_on before edge", 1'b0, rx_lanes_on);
    @(negedge clk_a);
    check_flag("rx_lanes_on after edge", 1'b1, rx_lanes_on);
    for (row_idx = 0; row_idx < NUM_ROWS; row_idx++)
      run_row(row_idx);
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule
